// File: source/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Data word width
`define MEM_DATA_W 8

// Host address width, the low bits select the bank
`define MEM_ADDR_W 8

// Number of banks, must be a power of two
`define MEM_BANKS 4

// Depth of every credit queue and initial credit count on every link
`define MEM_CREDITS 4

// Width of the response tag
`define MEM_TAG_W 4

`endif

// File: source/mem_bus_pkg.sv
`include "mem_cfg.svh"

package mem_bus_pkg;

	////////////////////////////////////////////////////////////////////
	// Host side of the memory subsystem
	////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_READ  = 2'd0,
		OP_WRITE = 2'd1,
		OP_CLEAR = 2'd2
	} mem_op_e;

	// Request from the host, address still holds the bank select bits
	typedef struct packed {
		mem_op_e                op;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] data;
		logic [`MEM_TAG_W-1:0]  tag;
	} mem_req_t;

	// Read response to the host
	typedef struct packed {
		logic [`MEM_TAG_W-1:0]  tag;
		logic [`MEM_DATA_W-1:0] data;
	} mem_rsp_t;

endpackage

// File: source/mem_bank_pkg.sv
`include "mem_cfg.svh"

package mem_bank_pkg;
	import mem_bus_pkg::mem_op_e;

	// Bank select bits and the word address that stays inside a bank
	localparam int BANK_SEL_W = $clog2(`MEM_BANKS);
	localparam int BANK_ADDR_W = `MEM_ADDR_W - BANK_SEL_W;

	typedef struct packed {
		mem_op_e                op;
		logic [BANK_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] data;
		logic [`MEM_TAG_W-1:0]  tag;
	} bank_req_t;

	typedef struct packed {
		logic [`MEM_TAG_W-1:0]  tag;
		logic [`MEM_DATA_W-1:0] data;
	} bank_rsp_t;

endpackage

// File: source/credit_fifo.sv
module credit_fifo #(
	parameter type item_t = logic,
	parameter int DEPTH = 4
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  push,
	input  item_t push_item,
	input  logic  pop,
	output item_t head,
	output logic  not_empty,
	output logic  credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t slots [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign not_empty = (count != '0);
	assign head = slots[rd_ptr];
	// A pop on an empty queue is ignored
	assign do_pop = pop && not_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(push) - CNT_W'(do_pop);
			// Freed slot goes back to the sender one cycle after the pop
			credit <= do_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			slots[wr_ptr] <= push_item;
		end
	end

endmodule

// File: source/request_router.sv
`include "mem_cfg.svh"

module request_router import mem_bus_pkg::*, mem_bank_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  req_valid,
	input  mem_req_t              req,
	output logic                  req_credit,
	output logic [`MEM_BANKS-1:0] bank_valid,
	output bank_req_t             bank_req [`MEM_BANKS],
	input  logic [`MEM_BANKS-1:0] bank_credit
);

	localparam int CNT_W = $clog2(`MEM_CREDITS + 1);

	mem_req_t head;
	logic head_valid;
	logic head_pop;
	logic [BANK_SEL_W-1:0] target;
	logic [CNT_W-1:0] bank_cnt [`MEM_BANKS];
	logic [`MEM_BANKS-1:0] has_credit;

	credit_fifo #(
		.item_t(mem_req_t),
		.DEPTH(`MEM_CREDITS)
	) req_queue (
		.clk,
		.reset,
		.push(req_valid),
		.push_item(req),
		.pop(head_pop),
		.head(head),
		.not_empty(head_valid),
		.credit(req_credit)
	);

	// Interleaving on the low address bits
	assign target = head.addr[BANK_SEL_W-1:0];

	always_comb begin
		for (int i = 0; i < `MEM_BANKS; i++) begin
			has_credit[i] = (bank_cnt[i] != '0);
		end
	end

	////////////////////////////////////////////////////////////////////
	// Dispatch of the head request
	////////////////////////////////////////////////////////////////////

	always_comb begin
		bank_valid = '0;
		if (head_valid) begin
			if (head.op == OP_CLEAR) begin
				// Broadcast only once every bank can take it
				if (&has_credit) begin
					bank_valid = '1;
				end
			end else if (has_credit[target]) begin
				bank_valid[target] = 1'b1;
			end
		end
	end

	assign head_pop = |bank_valid;

	// All banks see the same payload, the valid bit picks the target
	always_comb begin
		for (int i = 0; i < `MEM_BANKS; i++) begin
			bank_req[i].op = head.op;
			bank_req[i].addr = head.addr[`MEM_ADDR_W-1:BANK_SEL_W];
			bank_req[i].data = head.data;
			bank_req[i].tag = head.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MEM_BANKS; i++) begin
				bank_cnt[i] <= CNT_W'(`MEM_CREDITS);
			end
		end else begin
			for (int i = 0; i < `MEM_BANKS; i++) begin
				bank_cnt[i] <= bank_cnt[i] - CNT_W'(bank_valid[i]) + CNT_W'(bank_credit[i]);
			end
		end
	end

endmodule

// File: source/ram_bank.sv
`include "mem_cfg.svh"

module ram_bank import mem_bus_pkg::*, mem_bank_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      in_valid,
	input  bank_req_t in_req,
	output logic      in_credit,
	output logic      rsp_valid,
	output bank_rsp_t rsp,
	input  logic      rsp_credit
);

	localparam int WORDS = 2 ** BANK_ADDR_W;
	localparam int CNT_W = $clog2(`MEM_CREDITS + 1);

	bank_req_t cur;
	logic cur_valid;
	logic pop;
	logic out_full;
	logic send;
	logic [CNT_W-1:0] rsp_cnt;
	logic [`MEM_DATA_W-1:0] data [WORDS];
	logic [WORDS-1:0] word_valid;

	credit_fifo #(
		.item_t(bank_req_t),
		.DEPTH(`MEM_CREDITS)
	) in_queue (
		.clk,
		.reset,
		.push(in_valid),
		.push_item(in_req),
		.pop(pop),
		.head(cur),
		.not_empty(cur_valid),
		.credit(in_credit)
	);

	// Read result waits in the output register for a merger credit
	assign send = out_full && (rsp_cnt != '0);
	assign rsp_valid = send;
	assign pop = cur_valid && (!out_full || send);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_full <= 1'b0;
			word_valid <= '0;
			rsp_cnt <= CNT_W'(`MEM_CREDITS);
		end else begin
			rsp_cnt <= rsp_cnt - CNT_W'(send) + CNT_W'(rsp_credit);
			if (pop && cur.op == OP_READ) begin
				out_full <= 1'b1;
			end else if (send) begin
				out_full <= 1'b0;
			end
			if (pop && cur.op == OP_WRITE) begin
				word_valid[cur.addr] <= 1'b1;
			end
			// Whole bank empties in one cycle
			if (pop && cur.op == OP_CLEAR) begin
				word_valid <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop && cur.op == OP_WRITE) begin
			data[cur.addr] <= cur.data;
		end
		if (pop && cur.op == OP_READ) begin
			rsp.tag <= cur.tag;
			rsp.data <= word_valid[cur.addr] ? data[cur.addr] : '0;
		end
	end

endmodule

// File: source/response_merger.sv
`include "mem_cfg.svh"

module response_merger import mem_bus_pkg::*, mem_bank_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [`MEM_BANKS-1:0] bank_valid,
	input  bank_rsp_t             bank_rsp [`MEM_BANKS],
	output logic [`MEM_BANKS-1:0] bank_credit,
	output logic                  rsp_valid,
	output mem_rsp_t              rsp,
	input  logic                  rsp_credit
);

	localparam int CNT_W = $clog2(`MEM_CREDITS + 1);

	bank_rsp_t q_head [`MEM_BANKS];
	logic [`MEM_BANKS-1:0] q_valid;
	logic [`MEM_BANKS-1:0] q_pop;
	logic [BANK_SEL_W-1:0] rr_ptr;
	logic [BANK_SEL_W-1:0] sel;
	logic found;
	logic fire;
	logic [CNT_W-1:0] host_cnt;

	for (genvar i = 0; i < `MEM_BANKS; i++) begin : g_queue
		credit_fifo #(
			.item_t(bank_rsp_t),
			.DEPTH(`MEM_CREDITS)
		) rsp_queue (
			.clk,
			.reset,
			.push(bank_valid[i]),
			.push_item(bank_rsp[i]),
			.pop(q_pop[i]),
			.head(q_head[i]),
			.not_empty(q_valid[i]),
			.credit(bank_credit[i])
		);
	end

	////////////////////////////////////////////////////////////////////
	// Round-robin pick, starting at the bank after the last winner
	////////////////////////////////////////////////////////////////////

	always_comb begin
		logic [BANK_SEL_W-1:0] idx;
		found = 1'b0;
		sel = rr_ptr;
		for (int k = 0; k < `MEM_BANKS; k++) begin
			// Index wraps since the bank count is a power of two
			idx = rr_ptr + BANK_SEL_W'(k);
			if (!found && q_valid[idx]) begin
				found = 1'b1;
				sel = idx;
			end
		end
	end

	assign fire = found && (host_cnt != '0);

	always_comb begin
		q_pop = '0;
		if (fire) begin
			q_pop[sel] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
			rr_ptr <= '0;
			host_cnt <= CNT_W'(`MEM_CREDITS);
		end else begin
			rsp_valid <= fire;
			host_cnt <= host_cnt - CNT_W'(fire) + CNT_W'(rsp_credit);
			if (fire) begin
				rr_ptr <= sel + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			rsp.tag <= q_head[sel].tag;
			rsp.data <= q_head[sel].data;
		end
	end

endmodule

// File: source/mem_subsystem.sv
`include "mem_cfg.svh"

module mem_subsystem import mem_bus_pkg::*, mem_bank_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     req_valid,
	input  mem_req_t req,
	output logic     req_credit,
	output logic     rsp_valid,
	output mem_rsp_t rsp,
	input  logic     rsp_credit
);

	// Router to bank links
	logic [`MEM_BANKS-1:0] bank_in_valid;
	logic [`MEM_BANKS-1:0] bank_in_credit;
	bank_req_t bank_req [`MEM_BANKS];

	// Bank to merger links
	logic [`MEM_BANKS-1:0] bank_out_valid;
	logic [`MEM_BANKS-1:0] bank_out_credit;
	bank_rsp_t bank_rsp [`MEM_BANKS];

	request_router router_i (
		.clk,
		.reset,
		.req_valid,
		.req,
		.req_credit,
		.bank_valid(bank_in_valid),
		.bank_req(bank_req),
		.bank_credit(bank_in_credit)
	);

	for (genvar i = 0; i < `MEM_BANKS; i++) begin : g_bank
		ram_bank bank_i (
			.clk,
			.reset,
			.in_valid(bank_in_valid[i]),
			.in_req(bank_req[i]),
			.in_credit(bank_in_credit[i]),
			.rsp_valid(bank_out_valid[i]),
			.rsp(bank_rsp[i]),
			.rsp_credit(bank_out_credit[i])
		);
	end

	response_merger merger_i (
		.clk,
		.reset,
		.bank_valid(bank_out_valid),
		.bank_rsp(bank_rsp),
		.bank_credit(bank_out_credit),
		.rsp_valid,
		.rsp,
		.rsp_credit
	);

endmodule

// File: verification/mem_subsystem_properties.sv
`include "mem_cfg.svh"

module mem_subsystem_properties import mem_bus_pkg::*; (
	input logic     clk,
	input logic     reset,
	input logic     req_valid,
	input mem_req_t req,
	input logic     req_credit,
	input logic     rsp_valid,
	input mem_rsp_t rsp,
	input logic     rsp_credit
);

	localparam int WORDS = 2 ** `MEM_ADDR_W;
	localparam int TAGS = 2 ** `MEM_TAG_W;

	// Shadow of the whole host address space
	logic [`MEM_DATA_W-1:0] shadow [WORDS];
	logic [WORDS-1:0] shadow_valid;
	logic [`MEM_DATA_W-1:0] exp_data [TAGS];
	logic [TAGS-1:0] pending;
	logic seen_req;
	int host_cnt;
	int in_flight;
	int fail_count = 0;

	always_ff @(posedge clk) begin
		if (reset) begin
			shadow_valid <= '0;
			pending <= '0;
			seen_req <= 1'b0;
			host_cnt <= `MEM_CREDITS;
			in_flight <= 0;
		end else begin
			host_cnt <= host_cnt - int'(req_valid) + int'(req_credit);
			in_flight <= in_flight + int'(rsp_valid) - int'(rsp_credit);
			if (req_valid) begin
				seen_req <= 1'b1;
			end
			if (req_valid && req.op == OP_CLEAR) begin
				shadow_valid <= '0;
			end
			if (req_valid && req.op == OP_WRITE) begin
				shadow_valid[req.addr] <= 1'b1;
			end
			if (rsp_valid) begin
				pending[rsp.tag] <= 1'b0;
			end
			if (req_valid && req.op == OP_READ) begin
				pending[req.tag] <= 1'b1;
			end
		end
	end

	// Per-bank order and in-order clears make the value final at acceptance
	always_ff @(posedge clk) begin
		if (req_valid && req.op == OP_WRITE) begin
			shadow[req.addr] <= req.data;
		end
		if (req_valid && req.op == OP_READ) begin
			exp_data[req.tag] <= shadow_valid[req.addr] ? shadow[req.addr] : '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks on the host ports
	//////////////////////////////////////////////////////////////////////

	idle_after_reset: assert property (@(posedge clk) disable iff (reset)
		!seen_req |-> (!rsp_valid && !req_credit))
	else begin
		$error("rsp_valid or req_credit went high before any request was sent");
		fail_count++;
	end

	read_data: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |-> (rsp.data == exp_data[rsp.tag]))
	else begin
		$error("mismatch at %0t: rsp.data expected %h actual %h",
			$time, $sampled(exp_data[rsp.tag]), $sampled(rsp.data));
		fail_count++;
	end

	known_tag: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |-> pending[rsp.tag])
	else begin
		$error("response arrived for tag %0d which has no read outstanding",
			$sampled(rsp.tag));
		fail_count++;
	end

	rsp_in_flight: assert property (@(posedge clk) disable iff (reset)
		in_flight <= `MEM_CREDITS)
	else begin
		$error("more responses in flight than the host granted credits for");
		fail_count++;
	end

	// A credit may only come back for a slot the host has used
	req_credit_range: assert property (@(posedge clk) disable iff (reset)
		(host_cnt >= 0) && (host_cnt <= `MEM_CREDITS))
	else begin
		$error("host request credit count went below zero or above its initial value");
		fail_count++;
	end

endmodule

bind mem_subsystem mem_subsystem_properties props_i (
	.clk(clk),
	.reset(reset),
	.req_valid(req_valid),
	.req(req),
	.req_credit(req_credit),
	.rsp_valid(rsp_valid),
	.rsp(rsp),
	.rsp_credit(rsp_credit)
);

// File: verification/mem_subsystem_tb.sv
`include "mem_cfg.svh"

module mem_subsystem_tb import mem_bus_pkg::*; ();

	localparam int ADDR_W = `MEM_ADDR_W;
	localparam int DATA_W = `MEM_DATA_W;
	localparam int SEL_W = $clog2(`MEM_BANKS);
	localparam int TIMEOUT = 2000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic req_valid = 1'b0;
	mem_req_t req = '0;
	logic req_credit;
	logic rsp_valid;
	mem_rsp_t rsp;
	logic rsp_credit = 1'b0;

	// Host side credit state
	int host_cnt = `MEM_CREDITS;
	int owed = 0;
	logic give_credit = 1'b0;
	logic hold_credits = 1'b0;
	logic [`MEM_TAG_W-1:0] next_tag = '0;
	logic [2**`MEM_TAG_W-1:0] outstanding = '0;
	int errors = 0;
	int tests = 0;

	mem_subsystem mem_subsystem_i (
		.clk,
		.reset,
		.req_valid,
		.req,
		.req_credit,
		.rsp_valid,
		.rsp,
		.rsp_credit
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Host credit and tag bookkeeping, sampled mid-cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset) begin
			if (req_valid) begin
				host_cnt--;
				if (req.op == OP_READ) begin
					outstanding[req.tag] = 1'b1;
				end
			end
			if (rsp_valid) begin
				outstanding[rsp.tag] = 1'b0;
				owed++;
			end
			if (req_credit) begin
				host_cnt++;
			end
			// Random stalls on the returned credits
			give_credit = (owed > 0) && !hold_credits && ($urandom % 4 != 0);
			if (give_credit) begin
				owed--;
			end
		end
	end

	always @(posedge clk) begin
		#1;
		rsp_credit = give_credit;
	end

	//////////////////////////////////////////////////////////////////////
	// Request tasks
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send(input mem_op_e op, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] data, input logic [`MEM_TAG_W-1:0] tag);
		int waited;
		waited = 0;
		while (host_cnt == 0 && waited < TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (host_cnt == 0) begin
			$display("timeout: no request credit came back from the DUT");
			errors++;
		end else begin
			req_valid = 1'b1;
			req.op = op;
			req.addr = addr;
			req.data = data;
			req.tag = tag;
			next_cycle();
			req_valid = 1'b0;
		end
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] addr);
		int waited;
		waited = 0;
		while (outstanding[next_tag] && waited < TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (outstanding[next_tag]) begin
			$display("timeout: no free response tag for a read");
			errors++;
		end else begin
			send(OP_READ, addr, '0, next_tag);
			next_tag = next_tag + 1'b1;
		end
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		send(OP_WRITE, addr, data, '0);
	endtask

	task automatic clear_all();
		send(OP_CLEAR, '0, '0, '0);
	endtask

	// Wait for all reads to return and all request credits to come back
	task automatic drain();
		int waited;
		waited = 0;
		while ((outstanding != '0 || host_cnt != `MEM_CREDITS) && waited < TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (outstanding != '0) begin
			$display("timeout: read responses still missing after the traffic stopped");
			errors++;
		end
		assert (host_cnt == `MEM_CREDITS) else begin
			$display("mismatch at %0t: host_cnt expected %0d actual %0d",
				$time, `MEM_CREDITS, host_cnt);
			errors++;
		end
	endtask

	function automatic int total_errors();
		return errors + mem_subsystem_i.props_i.fail_count;
	endfunction

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s finished, %0d errors so far", tests, name, total_errors());
	endtask

	task automatic wait_for_full_host();
		int waited;
		waited = 0;
		while (owed < `MEM_CREDITS && waited < TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (owed < `MEM_CREDITS) begin
			$display("timeout: responses did not reach the host while credits were held");
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [ADDR_W-1:0] addr;
		void'($urandom(32'hc5bdaa64));
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (10) next_cycle();
		finish_test("idle after reset");

		read_word(ADDR_W'(8'h35));
		write_word(ADDR_W'(8'h35), DATA_W'(8'ha7));
		read_word(ADDR_W'(8'h35));
		for (int b = 0; b < `MEM_BANKS; b++) begin
			read_word(ADDR_W'(8'h40 + b));
		end
		drain();
		finish_test("read after write");

		for (int b = 0; b < `MEM_BANKS; b++) begin
			write_word(ADDR_W'(8'h10 + b), DATA_W'(8'hc0 + b));
			read_word(ADDR_W'(8'h10 + b));
		end
		clear_all();
		for (int b = 0; b < `MEM_BANKS; b++) begin
			read_word(ADDR_W'(8'h10 + b));
		end
		for (int b = 0; b < `MEM_BANKS; b++) begin
			write_word(ADDR_W'(8'h10 + b), DATA_W'(8'h5a ^ b));
			read_word(ADDR_W'(8'h10 + b));
		end
		drain();
		finish_test("clear");

		// Narrow address range so reads often hit written words
		for (int n = 0; n < 60; n++) begin
			addr = ADDR_W'($urandom % 32);
			if ($urandom % 3 == 0) begin
				write_word(addr, DATA_W'($urandom));
			end else begin
				read_word(addr);
			end
		end
		drain();
		finish_test("random traffic");

		// One bank only, so the back-pressure reaches the router
		hold_credits = 1'b1;
		for (int n = 0; n < 2 ** `MEM_TAG_W; n++) begin
			addr = ADDR_W'($urandom);
			addr[SEL_W-1:0] = '0;
			read_word(addr);
		end
		wait_for_full_host();
		repeat (30) next_cycle();
		hold_credits = 1'b0;
		drain();
		finish_test("response back-pressure");

		for (int n = 0; n < 24; n++) begin
			write_word(ADDR_W'($urandom), DATA_W'($urandom));
		end
		for (int n = 0; n < 8; n++) begin
			read_word(ADDR_W'($urandom));
		end
		drain();
		finish_test("request credits");

		$display("%0d tests finished, %0d errors", tests, total_errors());
		if (total_errors() == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#500000;
		$display("timeout: simulation ran past its time limit");
		$display("Verification failed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+source
source/mem_bus_pkg.sv
source/mem_bank_pkg.sv
source/credit_fifo.sv
source/request_router.sv
source/ram_bank.sv
source/response_merger.sv
source/mem_subsystem.sv
verification/mem_subsystem_properties.sv
verification/mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_subsystem_tb -f flist.f -o sim

output=$(./obj_dir/sim +verilator+error+limit+1000 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
